// File: include/vga_config.svh
`ifndef VGA_CONFIG_SVH
`define VGA_CONFIG_SVH

// 640 x 480 at 60 Hz, 25 MHz pixel clock
// horizontal phase lengths in pixel clocks
`define VGA_H_ACTIVE 10'd640
`define VGA_H_FRONT  10'd16
`define VGA_H_PULSE  10'd96
`define VGA_H_BACK   10'd48

// vertical phase lengths in lines
`define VGA_V_ACTIVE 10'd480
`define VGA_V_FRONT  10'd10
`define VGA_V_PULSE  10'd2
`define VGA_V_BACK   10'd33

// pixel buffer between source and scan-out
`define VGA_FIFO_DEPTH 8

// credit counter, wide enough to hold a full FIFO
`define VGA_CREDIT_W 4

`endif

// File: hw/vga_pkg.sv
`default_nettype none

package vga_pkg;

    // RRR GGG BB
    typedef struct packed {
        logic [2:0] red;
        logic [2:0] green;
        logic [1:0] blue;
    } rgb332_t;

    // same byte read either as colour or as grey level
    typedef union packed {
        rgb332_t    rgb;
        logic [7:0] gray;
    } pixel_u;

    // phase order matters, the machines step through it in sequence
    typedef enum logic [1:0] {
        ph_active = 2'd0,
        ph_front  = 2'd1,
        ph_pulse  = 2'd2,
        ph_back   = 2'd3
    } phase_t;

endpackage

`default_nettype wire

// File: hw/vga_ifs.sv
`timescale 1ns/10ps
`default_nettype none

// scan position and syncs from the timing generator
interface vga_timing_if;

    logic       hsync;       // low during horizontal pulse
    logic       vsync;       // low during vertical pulse
    logic       active;
    logic [9:0] x;
    logic [9:0] y;
    logic       frame_start; // first cycle of vertical pulse

    modport drive (output hsync, vsync, active, x, y, frame_start);
    modport sink  (input  hsync, vsync, active, x, y, frame_start);

endinterface

// pixel stream under credit flow control
interface pix_credit_if;

    import vga_pkg::*;

    logic   valid;
    pixel_u pixel;
    logic   sof;    // pixel (0,0)
    logic   credit; // one slot freed in the sink

    modport source (
        output valid, pixel, sof,
        input  credit
    );

    modport sink (
        input  valid, pixel, sof,
        output credit
    );

endinterface

`default_nettype wire

// File: hw/vga_timing.sv
`timescale 1ns/10ps
`default_nettype none
`include "vga_config.svh"

module vga_timing (
    input  logic        clk,
    input  logic        rst,
    vga_timing_if.drive tim
);

    import vga_pkg::*;

    phase_t     h_phase, v_phase;
    logic [9:0] h_cnt, v_cnt;    // position inside the current phase
    logic [9:0] h_last, v_last;
    logic       line_end;

    function automatic phase_t next_phase(input phase_t ph);
        case (ph)
            ph_active: return ph_front;
            ph_front:  return ph_pulse;
            ph_pulse:  return ph_back;
            default:   return ph_active;
        endcase
    endfunction

    // last count of each phase
    always_comb begin
        case (h_phase)
            ph_active: h_last = `VGA_H_ACTIVE - 10'd1;
            ph_front:  h_last = `VGA_H_FRONT - 10'd1;
            ph_pulse:  h_last = `VGA_H_PULSE - 10'd1;
            default:   h_last = `VGA_H_BACK - 10'd1;
        endcase
        case (v_phase)
            ph_active: v_last = `VGA_V_ACTIVE - 10'd1;
            ph_front:  v_last = `VGA_V_FRONT - 10'd1;
            ph_pulse:  v_last = `VGA_V_PULSE - 10'd1;
            default:   v_last = `VGA_V_BACK - 10'd1;
        endcase
    end

    assign line_end = (h_phase == ph_back) && (h_cnt == h_last);

    // start on the last cycle of back porch so the source gets a head start
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_phase <= ph_back;
            h_cnt   <= `VGA_H_BACK - 10'd1;
            v_phase <= ph_back;
            v_cnt   <= `VGA_V_BACK - 10'd1;
        end else begin
            if (h_cnt == h_last) begin
                h_cnt   <= 10'd0;
                h_phase <= next_phase(h_phase);
            end else begin
                h_cnt <= h_cnt + 10'd1;
            end

            // vertical machine steps once per line
            if (line_end) begin
                if (v_cnt == v_last) begin
                    v_cnt   <= 10'd0;
                    v_phase <= next_phase(v_phase);
                end else begin
                    v_cnt <= v_cnt + 10'd1;
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tim.hsync       <= 1'b1;
            tim.vsync       <= 1'b1;
            tim.active      <= 1'b0;
            tim.x           <= 10'd0;
            tim.y           <= 10'd0;
            tim.frame_start <= 1'b0;
        end else begin
            tim.hsync  <= (h_phase != ph_pulse);
            tim.vsync  <= (v_phase != ph_pulse);
            tim.active <= (h_phase == ph_active) && (v_phase == ph_active);
            tim.x      <= (h_phase == ph_active) ? h_cnt : 10'd0;
            tim.y      <= (v_phase == ph_active) ? v_cnt : 10'd0;
            // vertical pulse always begins with the first pixel slot of a line
            tim.frame_start <= (v_phase == ph_pulse) && (v_cnt == 10'd0) &&
                               (h_phase == ph_active) && (h_cnt == 10'd0);
        end
    end

endmodule

`default_nettype wire

// File: hw/pixel_source.sv
`timescale 1ns/10ps
`default_nettype none
`include "vga_config.svh"

module pixel_source (
    input  logic         clk,
    input  logic         rst,
    pix_credit_if.source pix
);

    logic [9:0]               px, py;  // raster position of the next pixel
    logic [`VGA_CREDIT_W-1:0] credits;
    logic                     send;

    assign send = (credits != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            px        <= 10'd0;
            py        <= 10'd0;
            credits   <= `VGA_CREDIT_W'(`VGA_FIFO_DEPTH); // sink FIFO empty
            pix.valid <= 1'b0;
        end else begin
            pix.valid <= send;
            // spend and return may land in the same cycle
            credits <= credits - `VGA_CREDIT_W'(send) + `VGA_CREDIT_W'(pix.credit);

            if (send) begin
                if (px == `VGA_H_ACTIVE - 10'd1) begin
                    px <= 10'd0;
                    if (py == `VGA_V_ACTIVE - 10'd1) begin
                        py <= 10'd0; // wrap to next frame
                    end else begin
                        py <= py + 10'd1;
                    end
                end else begin
                    px <= px + 10'd1;
                end
            end
        end
    end

    // pattern payload, qualified by valid
    always_ff @(posedge clk) begin
        if (send) begin
            pix.pixel <= px[7:0] ^ py[7:0];
            pix.sof   <= (px == 10'd0) && (py == 10'd0);
        end
    end

endmodule

`default_nettype wire

// File: hw/video_out.sv
`timescale 1ns/10ps
`default_nettype none
`include "vga_config.svh"

module video_out (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  key,
    input  logic        gray_mode,
    vga_timing_if.sink  tim,
    pix_credit_if.sink  pix,
    output logic        hsync,
    output logic        vsync,
    output logic        blank,
    output logic [7:0]  red,
    output logic [7:0]  green,
    output logic [7:0]  blue,
    output logic        sync_error
);

    import vga_pkg::*;

    localparam int unsigned addr_w = $clog2(`VGA_FIFO_DEPTH);

    logic [8:0]               mem [`VGA_FIFO_DEPTH]; // {sof, pixel}
    logic [addr_w-1:0]        wr_ptr, rd_ptr;
    logic [`VGA_CREDIT_W-1:0] count;
    logic                     push, pop, empty;
    logic                     head_sof;
    pixel_u                   head_pix;
    pixel_u                   word;
    logic [7:0]               frame_key;
    logic                     frame_gray;
    logic                     at_origin;
    logic                     bad;
    logic [7:0]               red_d, green_d, blue_d;

    assign push  = pix.valid;  // never refused, credits guarantee space
    assign empty = (count == '0);
    assign pop   = tim.active && !empty;
    assign pix.credit = pop;

    assign {head_sof, head_pix} = mem[rd_ptr];
    assign word = head_pix ^ frame_key;

    assign at_origin = (tim.x == 10'd0) && (tim.y == 10'd0);
    // starved scan or source out of step with the raster
    assign bad = tim.active && (empty || (head_sof != at_origin));

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {pix.sof, pix.pixel};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1; // depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + `VGA_CREDIT_W'(push) - `VGA_CREDIT_W'(pop);
        end
    end

    // key and mode hold for a whole frame
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            frame_key  <= 8'd0;
            frame_gray <= 1'b0;
        end else if (tim.frame_start) begin
            frame_key  <= key;
            frame_gray <= gray_mode;
        end
    end

    always_comb begin
        if (frame_gray) begin
            red_d   = word.gray;
            green_d = word.gray;
            blue_d  = word.gray;
        end else begin
            // repeat field bits from the top to fill 8 bits
            red_d   = {word.rgb.red, word.rgb.red, word.rgb.red[2:1]};
            green_d = {word.rgb.green, word.rgb.green, word.rgb.green[2:1]};
            blue_d  = {4{word.rgb.blue}};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hsync      <= 1'b1;
            vsync      <= 1'b1;
            blank      <= 1'b1;
            red        <= 8'd0;
            green      <= 8'd0;
            blue       <= 8'd0;
            sync_error <= 1'b0;
        end else begin
            hsync <= tim.hsync;  // one stage, matches the colour path
            vsync <= tim.vsync;
            blank <= !tim.active;
            if (tim.active && !bad) begin
                red   <= red_d;
                green <= green_d;
                blue  <= blue_d;
            end else begin
                red   <= 8'd0; // blanking or a bad pixel shows black
                green <= 8'd0;
                blue  <= 8'd0;
            end
            sync_error <= sync_error || bad; // sticky
        end
    end

endmodule

`default_nettype wire

// File: hw/vga_top.sv
`timescale 1ns/10ps
`default_nettype none

module vga_top (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] key,
    input  logic       gray_mode,
    output logic       hsync,
    output logic       vsync,
    output logic       blank,
    output logic [7:0] red,
    output logic [7:0] green,
    output logic [7:0] blue,
    output logic       sync_error
);

    vga_timing_if tim_if ();
    pix_credit_if pix_if ();

    vga_timing i_timing (
        .clk (clk),
        .rst (rst),
        .tim (tim_if.drive)
    );

    // runs ahead of the scan, limited only by credits
    pixel_source i_source (
        .clk (clk),
        .rst (rst),
        .pix (pix_if.source)
    );

    video_out i_out (
        .clk        (clk),
        .rst        (rst),
        .key        (key),
        .gray_mode  (gray_mode),
        .tim        (tim_if.sink),
        .pix        (pix_if.sink),
        .hsync      (hsync),
        .vsync      (vsync),
        .blank      (blank),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .sync_error (sync_error)
    );

endmodule

`default_nettype wire

// File: tb/vga_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "vga_config.svh"

module vga_tb;

    import vga_pkg::*;

    localparam int clk_period  = 8;
    localparam int line_cycles = `VGA_H_ACTIVE + `VGA_H_FRONT + `VGA_H_PULSE + `VGA_H_BACK;
    localparam int frame_lines = `VGA_V_ACTIVE + `VGA_V_FRONT + `VGA_V_PULSE + `VGA_V_BACK;
    localparam int h_active    = `VGA_H_ACTIVE;
    localparam int v_active    = `VGA_V_ACTIVE;
    localparam int hsync_start = `VGA_H_ACTIVE + `VGA_H_FRONT; // from first active cycle
    localparam int hsync_len   = `VGA_H_PULSE;
    localparam int vsync_len   = `VGA_V_PULSE * line_cycles;
    localparam int frames_run  = 3;                            // vsync falls before the end
    localparam int cycle_limit = 3 * line_cycles * frame_lines + 100;

    logic       clk = 1'b0;
    logic       rst;
    logic [7:0] key;
    logic       gray_mode;
    logic       hsync, vsync, blank;
    logic [7:0] red, green, blue;
    logic       sync_error;

    int cycles = 0;

    // reference model state
    logic       prev_hsync, prev_vsync, prev_blank;
    bit         seen_active;
    bit         hfall_seen, vfall_seen, line_active;
    int         px, py, cur_x;
    int         active_lines, line_count, vfalls, pixels_checked;
    int         since_hfall, since_active, hlow_cnt, vlow_cnt;
    phase_t     h_ph;
    logic [7:0] frame_key;
    bit         frame_gray;
    int         change_line, change_x;
    bit         changed;

    vga_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .key        (key),
        .gray_mode  (gray_mode),
        .hsync      (hsync),
        .vsync      (vsync),
        .blank      (blank),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .sync_error (sync_error)
    );

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: scan did not reach %0d vsync falls in %0d cycles",
                     frames_run, cycle_limit);
            $display("Regression failed");
            $fatal(1, "simulation ran past its cycle limit");
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("Regression failed");
            $fatal(1, "check %s did not match", name);
        end
    endtask

    // RGB332 fields widened by repeating bits from the top
    function automatic logic [23:0] expected_rgb(input logic [7:0] v, input bit gray);
        logic [2:0] r, g;
        logic [1:0] b;
        r = v[7:5];
        g = v[4:2];
        b = v[1:0];
        if (gray) begin
            return {v, v, v}; // grey level on all channels
        end
        return {r, r, r[2:1], g, g, g[2:1], b, b, b, b};
    endfunction

    // one random slot per frame on lines 100 to 300 for new key and mode
    task automatic plan_input_change();
        change_line = $urandom_range(300, 100);
        change_x    = $urandom_range(h_active - 1, 0);
        changed     = 1'b0;
    endtask

    task automatic step_model();
        logic [7:0] v;
        since_hfall  = since_hfall + 1;
        since_active = since_active + 1;
        check_value("sync_error low", 0, sync_error);

        if (!seen_active && blank) begin // still before the first active cycle
            check_value("hsync idle after reset", 1, hsync);
            check_value("vsync idle after reset", 1, vsync);
            check_value("rgb black after reset", 0, {red, green, blue});
        end

        if (prev_blank && !blank) begin
            seen_active  = 1'b1;
            line_active  = 1'b1;
            px           = 0;
            since_active = 0;
            h_ph         = ph_active;
        end

        if (!blank) begin
            v = px[7:0] ^ py[7:0] ^ frame_key;
            check_value($sformatf("%s pixel x=%0d y=%0d", frame_gray ? "grey" : "colour",
                                  px, py), expected_rgb(v, frame_gray), {red, green, blue});
            pixels_checked = pixels_checked + 1;
            cur_x = px;
            px    = px + 1;
        end else begin
            check_value("rgb zero in blanking", 0, {red, green, blue});
            cur_x = -1;
        end

        if (!prev_blank && blank) begin
            check_value($sformatf("active pixels on line %0d", py), h_active, px);
            py           = py + 1;
            active_lines = active_lines + 1;
            h_ph         = ph_front;
        end

        if (prev_hsync && !hsync) begin
            if (hfall_seen) begin
                check_value("line period", line_cycles, since_hfall);
            end
            if (line_active) begin
                check_value($sformatf("hsync start after %s", h_ph.name()),
                            hsync_start, since_active);
            end
            hfall_seen  = 1'b1;
            line_active = 1'b0;
            since_hfall = 0;
            hlow_cnt    = 0;
            line_count  = line_count + 1;
            h_ph        = ph_pulse;
        end
        if (!hsync) begin
            hlow_cnt = hlow_cnt + 1;
        end
        if (!prev_hsync && hsync) begin
            check_value($sformatf("hsync length in %s", h_ph.name()), hsync_len, hlow_cnt);
            h_ph = ph_back;
        end

        if (prev_vsync && !vsync) begin
            check_value("active lines per frame", v_active, active_lines);
            if (vfall_seen) begin
                check_value("lines per frame", frame_lines, line_count);
            end
            frame_key    = key;       // value the DUT took at frame start
            frame_gray   = gray_mode;
            vfall_seen   = 1'b1;
            line_count   = 0;
            vlow_cnt     = 0;
            active_lines = 0;
            py           = 0;
            vfalls       = vfalls + 1;
            plan_input_change();
        end
        if (!vsync) begin
            vlow_cnt = vlow_cnt + 1;
        end
        if (!prev_vsync && vsync) begin
            check_value("vsync low cycles", vsync_len, vlow_cnt);
        end

        prev_hsync = hsync;
        prev_vsync = vsync;
        prev_blank = blank;
    endtask

    task automatic drive_inputs();
        if (!changed && !blank && py == change_line && cur_x == change_x) begin
            key       = 8'($urandom_range(255, 0));
            // second frame always grey, later frames random
            gray_mode = (vfalls == 0) ? 1'b1 : 1'($urandom_range(1, 0));
            changed   = 1'b1;
        end
    endtask

    initial begin
        void'($urandom(32'he029));
        rst            = 1'b1;
        key            = 8'd0;
        gray_mode      = 1'b0;
        prev_hsync     = 1'b1;
        prev_vsync     = 1'b1;
        prev_blank     = 1'b1;
        seen_active    = 1'b0;
        hfall_seen     = 1'b0;
        vfall_seen     = 1'b0;
        line_active    = 1'b0;
        px             = 0;
        py             = 0;
        cur_x          = -1;
        active_lines   = 0;
        line_count     = 0;
        vfalls         = 0;
        pixels_checked = 0;
        since_hfall    = 0;
        since_active   = 0;
        hlow_cnt       = 0;
        vlow_cnt       = 0;
        h_ph           = ph_back;
        frame_key      = 8'd0; // frame registers clear on reset
        frame_gray     = 1'b0;
        plan_input_change();

        repeat (3) @(posedge clk);
        @(negedge clk);
        check_value("blank high after reset", 1, blank);
        rst = 1'b0;

        while (vfalls < frames_run) begin
            @(negedge clk);
            step_model();
            drive_inputs();
        end

        $display("checked %0d active pixels over %0d frames", pixels_checked, frames_run);
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vga_top.f
+incdir+include
hw/vga_pkg.sv
hw/vga_ifs.sv
hw/vga_timing.sv
hw/pixel_source.sv
hw/video_out.sv
hw/vga_top.sv
tb/vga_tb.sv

// File: Bender.yml
package:
  name: vga_top

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/vga_pkg.sv
      - hw/vga_ifs.sv
      - hw/vga_timing.sv
      - hw/pixel_source.sv
      - hw/video_out.sv
      - hw/vga_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - tb/vga_tb.sv
